// ==== act_settings.svh ====
//====================================================================
// build-time widths for the activation stream path
// include wherever a width or the buffer depth is needed
//====================================================================
`ifndef ACT_SETTINGS_SVH
`define ACT_SETTINGS_SVH

// one global buffer word
`define ACT_PORT_WIDTH 32
// one activation item
`define ACT_DATA_WIDTH 8
// buffer address, depth is 2**width words
`define ACT_GBF_ADDR_WIDTH 4
// items carried by one buffer word
`define ACT_ITEMS_PER_WORD (`ACT_PORT_WIDTH / `ACT_DATA_WIDTH)

`endif

// ==== act_pkg.sv ====
//====================================================================
// shared types of the activation stream path
// referenced by scoped name from the RTL and the testbench
//====================================================================
`default_nettype none

`include "act_settings.svh"

package act_pkg;

    typedef logic [`ACT_PORT_WIDTH-1:0]     port_word_t;
    typedef logic [`ACT_DATA_WIDTH-1:0]     act_item_t;
    typedef logic [`ACT_GBF_ADDR_WIDTH-1:0] gbf_addr_t;
    // one extra bit so a completely full buffer can be counted
    typedef logic [`ACT_GBF_ADDR_WIDTH:0]   gbf_count_t;

    typedef enum logic [1:0] {
        UNP_EMPTY   = 2'd0,
        UNP_LOADING = 2'd1,
        UNP_HOLD    = 2'd2
    } unp_state_e;

endpackage

`default_nettype wire

// ==== gbf_ram.sv ====
//====================================================================
// global buffer memory, one write port and one read port
// read data is registered and holds between reads
//====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "act_settings.svh"

module gbf_ram (
    input  wire                logic clk,
    input  wire                logic wr_en,
    input  act_pkg::gbf_addr_t       wr_addr,
    input  act_pkg::port_word_t      wr_data,
    input  wire                logic rd_en,
    input  act_pkg::gbf_addr_t       rd_addr,
    output act_pkg::port_word_t      rd_data
);

    localparam int DEPTH = 1 << `ACT_GBF_ADDR_WIDTH;

    act_pkg::port_word_t mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== gbf_fetch.sv ====
//====================================================================
// fetch stage between the global buffer and the unpacker
// tracks occupancy, fires one read per rising edge of all-ready
// and delays the read strobe into the unpacker load strobe
//====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "act_settings.svh"

module gbf_fetch (
    input  wire                logic clk,
    input  wire                logic rst_n,
    input  wire                logic wr_en,
    input  wire                logic word_rdy,
    output logic                     full,
    output logic                     rd_en,
    output act_pkg::gbf_addr_t       rd_addr,
    output logic                     word_load
);

    act_pkg::gbf_count_t count;
    logic                buf_valid;
    logic                all_rdy;
    logic                all_rdy_d;

    //====================================================================
    // fetch trigger
    //====================================================================

    // write first, a cycle with a write never reads
    assign buf_valid = (count != '0) && !wr_en;
    assign all_rdy   = buf_valid && word_rdy;

    // one pulse per rising edge of all-ready
    assign rd_en = all_rdy && !all_rdy_d;

    // count never exceeds the depth, so the top bit alone flags full
    assign full = count[`ACT_GBF_ADDR_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            all_rdy_d <= 1'b0;
            word_load <= 1'b0;
        end else begin
            all_rdy_d <= all_rdy;
            // data is on rd_data one cycle after the read
            word_load <= rd_en;
        end
    end

    //====================================================================
    // occupancy and read pointer
    //====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // wraps modulo the depth, same as the writer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== act_unpacker.sv ====
//====================================================================
// activation unpacker, takes one buffer word and hands out its
// items one per take, most significant item first
//====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "act_settings.svh"

module act_unpacker (
    input  wire                logic clk,
    input  wire                logic rst_n,
    output logic                     word_rdy,
    input  wire                logic fetch,
    input  wire                logic word_load,
    input  act_pkg::port_word_t      word_in,
    output logic                     act_rdy,
    input  wire                logic act_en,
    output act_pkg::act_item_t       act_data
);

    localparam int CNT_W = $clog2(`ACT_ITEMS_PER_WORD);
    localparam logic [CNT_W-1:0] ITEM_LAST = CNT_W'(`ACT_ITEMS_PER_WORD - 1);

    act_pkg::unp_state_e state;
    act_pkg::port_word_t shift_reg;
    logic [CNT_W-1:0]    item_cnt;
    logic                take;

    assign word_rdy = (state == act_pkg::UNP_EMPTY);
    assign act_rdy  = (state == act_pkg::UNP_HOLD);
    assign take     = act_rdy && act_en;

    // top item of the held word
    assign act_data = shift_reg[`ACT_PORT_WIDTH-1 -: `ACT_DATA_WIDTH];

    //====================================================================
    // state machine
    //====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= act_pkg::UNP_EMPTY;
            item_cnt <= '0;
        end else begin
            case (state)
                act_pkg::UNP_EMPTY: begin
                    if (fetch) begin
                        state <= act_pkg::UNP_LOADING;
                    end
                end
                act_pkg::UNP_LOADING: begin
                    if (word_load) begin
                        state    <= act_pkg::UNP_HOLD;
                        item_cnt <= '0;
                    end
                end
                act_pkg::UNP_HOLD: begin
                    if (take) begin
                        item_cnt <= item_cnt + 1'b1;
                        // last item gone, ask for the next word
                        if (item_cnt == ITEM_LAST) begin
                            state <= act_pkg::UNP_EMPTY;
                        end
                    end
                end
                default: state <= act_pkg::UNP_EMPTY;
            endcase
        end
    end

    // word capture and left shift by one item per take
    always_ff @(posedge clk) begin
        if (state == act_pkg::UNP_LOADING && word_load) begin
            shift_reg <= word_in;
        end else if (take) begin
            shift_reg <= {shift_reg[`ACT_PORT_WIDTH-`ACT_DATA_WIDTH-1:0],
                          {`ACT_DATA_WIDTH{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// ==== act_stream_top.sv ====
//====================================================================
// activation data path top, global buffer feeding the unpacker
// through the fetch stage; writer and consumer sit outside
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module act_stream_top (
    input  wire                logic clk,
    input  wire                logic rst_n,
    input  wire                logic wr_en,
    input  act_pkg::gbf_addr_t       wr_addr,
    input  act_pkg::port_word_t      wr_data,
    output logic                     full,
    output logic                     act_rdy,
    input  wire                logic act_en,
    output act_pkg::act_item_t       act_data
);

    logic                rd_en;
    act_pkg::gbf_addr_t  rd_addr;
    act_pkg::port_word_t rd_data;
    logic                word_rdy;
    logic                word_load;

    gbf_ram u_gbf_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    gbf_fetch u_gbf_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .word_rdy  (word_rdy),
        .full      (full),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .word_load (word_load)
    );

    // the read strobe doubles as the unpacker fetch cue
    act_unpacker u_act_unpacker (
        .clk       (clk),
        .rst_n     (rst_n),
        .word_rdy  (word_rdy),
        .fetch     (rd_en),
        .word_load (word_load),
        .word_in   (rd_data),
        .act_rdy   (act_rdy),
        .act_en    (act_en),
        .act_data  (act_data)
    );

endmodule

`default_nettype wire

// ==== act_stream_chk.sv ====
//======================================================================
// handshake checker for the activation stream top
// attached to every act_stream_top instance by the bind below
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module act_stream_chk (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic wr_en,
    input  wire logic full,
    input  wire logic rd_en,
    input  wire logic act_rdy,
    input  wire logic act_en
);

    // consumer only asks for an item that is on offer
    take_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        act_en |-> act_rdy)
        else $error("act_en high while act_rdy is low");

    // writer backs off while the buffer is full
    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !full)
        else $error("write into a full buffer");

    // write first, a write cycle never fetches
    no_read_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_en && wr_en))
        else $error("buffer read in a cycle with a write");

endmodule

bind act_stream_top act_stream_chk u_act_stream_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .full    (full),
    .rd_en   (rd_en),
    .act_rdy (act_rdy),
    .act_en  (act_en)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
//======================================================================
// testbench clock and reset source
// 20 ns clock, reset held low for the first 4 cycles
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk = ~clk;
        end
    end

    // release on a falling edge, away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== act_stream_tb.sv ====
//======================================================================
// testbench for the activation stream top
// streams the words of act_vectors.txt under consumer stalls, then
// fills the buffer with a back-to-back burst and drains it
//======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "act_settings.svh"

module act_stream_tb;

    localparam int COLS        = 6;
    localparam int NUM_LINES   = 22;
    localparam int DEPTH       = 1 << `ACT_GBF_ADDR_WIDTH;
    localparam int ITEMS       = `ACT_ITEMS_PER_WORD;
    localparam int TOTAL_ITEMS = (NUM_LINES + DEPTH) * ITEMS;
    localparam int WDOG_CYCLES = (NUM_LINES + DEPTH) * 200;

    logic                clk;
    logic                rst_n;
    logic                wr_en;
    act_pkg::gbf_addr_t  wr_addr;
    act_pkg::port_word_t wr_data;
    logic                full;
    logic                act_rdy;
    logic                act_en;
    act_pkg::act_item_t  act_data;

    // per line: word, items msb first, stall flag
    logic [`ACT_PORT_WIDTH-1:0] vec_mem [0:NUM_LINES*COLS-1];

    // expected stream in write order
    act_pkg::act_item_t exp_mem   [0:TOTAL_ITEMS-1];
    logic               stall_mem [0:TOTAL_ITEMS-1];
    act_pkg::gbf_addr_t wr_ptr;
    int                 pushed;
    int                 taken;
    logic               hold_consumer;
    integer             seed;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    act_stream_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .full     (full),
        .act_rdy  (act_rdy),
        .act_en   (act_en),
        .act_data (act_data)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // called on a falling edge, the write lands on the next rising edge
    task automatic write_line(input int line);
        int k;
        wr_en   <= 1'b1;
        wr_addr <= wr_ptr;
        wr_data <= vec_mem[line*COLS];
        wr_ptr   = wr_ptr + act_pkg::gbf_addr_t'(1);
        for (k = 0; k < ITEMS; k++) begin
            exp_mem[pushed + k]   = vec_mem[line*COLS + 1 + k][`ACT_DATA_WIDTH-1:0];
            stall_mem[pushed + k] = vec_mem[line*COLS + 1 + ITEMS][0];
        end
        pushed += ITEMS;
    endtask

    task automatic wait_drained();
        while (taken < pushed) begin
            @(negedge clk);
        end
    endtask

    //==================================================================
    // writer
    //==================================================================
    initial begin : writer
        int i;
        wr_en         <= 1'b0;
        wr_addr       <= '0;
        wr_data       <= '0;
        wr_ptr        = '0;
        pushed        = 0;
        hold_consumer = 1'b0;
        $readmemh("act_vectors.txt", vec_mem);
        @(posedge rst_n);

        // idle outputs after reset
        repeat (3) begin
            @(negedge clk);
            assert (!act_rdy && !full) else
                abort_run($sformatf("FAIL t=%0t act_rdy %b full %b after reset",
                                    $time, act_rdy, full));
        end

        // uneven gaps, more words than the buffer holds
        for (i = 0; i < NUM_LINES; i++) begin
            @(negedge clk);
            wr_en <= 1'b0;
            repeat (i % 3) @(negedge clk);
            while (full) @(negedge clk);
            write_line(i);
        end
        @(negedge clk);
        wr_en <= 1'b0;
        wait_drained();

        // consumer stalled, one write per cycle into the empty buffer
        hold_consumer = 1'b1;
        @(negedge clk);
        for (i = 0; i < DEPTH; i++) begin
            assert (!full && !act_rdy) else
                abort_run($sformatf("FAIL t=%0t full %b act_rdy %b before burst write %0d",
                                    $time, full, act_rdy, i));
            write_line(i);
            @(negedge clk);
        end
        wr_en <= 1'b0;
        assert (full && !act_rdy) else
            abort_run($sformatf("FAIL t=%0t full %b act_rdy %b after %0d writes",
                                $time, full, act_rdy, DEPTH));

        // fetch follows the burst, the word then waits for the consumer
        while (!act_rdy) @(negedge clk);
        assert (!full) else
            abort_run($sformatf("FAIL t=%0t full still high after a fetch", $time));
        repeat (4) @(negedge clk);
        hold_consumer = 1'b0;
        wait_drained();

        repeat (4) begin
            @(negedge clk);
            assert (!act_rdy && !full && taken == TOTAL_ITEMS) else
                abort_run($sformatf("FAIL t=%0t act_rdy %b full %b after %0d of %0d items",
                                    $time, act_rdy, full, taken, TOTAL_ITEMS));
        end
        $display("Test OK");
        $finish;
    end

    //==================================================================
    // consumer
    //==================================================================
    initial begin : consumer
        logic               held;
        logic               took;
        logic [31:0]        rnd;
        act_pkg::act_item_t held_data;
        seed      = 32'heb9d_0c39;
        act_en    <= 1'b0;
        taken     = 0;
        held      = 1'b0;
        held_data = '0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            took = 1'b0;
            // an item not taken stays on the bus
            if (held) begin
                assert (act_rdy && act_data == held_data) else
                    abort_run($sformatf("FAIL t=%0t held item %h rdy %b, expected %h",
                                        $time, act_data, act_rdy, held_data));
            end
            rnd = $random(seed);
            if (act_rdy && !hold_consumer) begin
                assert (taken < pushed) else
                    abort_run("DUT offered an item beyond the words written");
                if (!(stall_mem[taken] && rnd[0])) begin
                    assert (act_data == exp_mem[taken]) else
                        abort_run($sformatf("FAIL t=%0t item %0d is %h, expected %h",
                                            $time, taken, act_data, exp_mem[taken]));
                    taken++;
                    took = 1'b1;
                end
            end
            act_en    <= took;
            held      = act_rdy && !took;
            held_data = act_data;
        end
    end

    initial begin : watchdog
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: item stream not finished after %0d cycles", WDOG_CYCLES);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== act_vectors.txt ====
// columns: write word, its four items msb first, consumer stall flag
// one line per buffer word, all values hex
3a7c91e4 3a 7c 91 e4 0
00ff00ff 00 ff 00 ff 1
12345678 12 34 56 78 0
deadbeef de ad be ef 1
80017f02 80 01 7f 02 1
c3a55a3c c3 a5 5a 3c 0
0badf00d 0b ad f0 0d 1
9e3779b9 9e 37 79 b9 0
01020304 01 02 03 04 1
fedcba98 fe dc ba 98 0
5566aa99 55 66 aa 99 1
7f80817e 7f 80 81 7e 1
00000000 00 00 00 00 0
ffffffff ff ff ff ff 1
a1b2c3d4 a1 b2 c3 d4 0
6c0ffee5 6c 0f fe e5 1
13579bdf 13 57 9b df 0
2468ace0 24 68 ac e0 1
b00b1e55 b0 0b 1e 55 1
4d3c2b1a 4d 3c 2b 1a 0
e7e7187e e7 e7 18 7e 1
5a5a0f0f 5a 5a 0f 0f 0

// ==== all.f ====
+incdir+.
act_pkg.sv
gbf_ram.sv
gbf_fetch.sv
act_unpacker.sv
act_stream_top.sv
act_stream_chk.sv
tb_clk_gen.sv
act_stream_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the activation stream testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module act_stream_tb -f all.f -o act_stream_sim
./obj_dir/act_stream_sim
